// ==== source/mdu_pkg.sv ====
package mdu_pkg;

    typedef logic [31:0] xlen_t;   // data word
    typedef logic [5:0]  preg_t;   // physical register tag
    typedef logic [2:0]  funct3_t;

    // RV32M funct3 encodings, high-half multiplies not supported
    localparam funct3_t F3_MUL  = 3'b000;
    localparam funct3_t F3_DIV  = 3'b100;
    localparam funct3_t F3_DIVU = 3'b101;
    localparam funct3_t F3_REM  = 3'b110;
    localparam funct3_t F3_REMU = 3'b111;

    typedef enum logic [2:0] {
        OP_MUL,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } mdu_op_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

    // wake sources: external, multiplier, divider
    localparam int WAKE_PORTS = 3;

endpackage

// ==== source/mdu_decode.sv ====
module mdu_decode import mdu_pkg::*; #(
    parameter int PREG_NUM = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    disp_valid,
    input  funct3_t                 disp_funct3,
    input  preg_t                   disp_prs1,
    input  preg_t                   disp_prs2,
    input  preg_t                   disp_prd,
    input  logic                    accept,
    input  logic [WAKE_PORTS-1:0]   wake_valid,
    input  preg_t [WAKE_PORTS-1:0]  wake_tag,
    output logic                    enq_valid,
    output mdu_op_t                 enq_op,
    output preg_t                   enq_prs1,
    output preg_t                   enq_prs2,
    output preg_t                   enq_prd,
    output logic                    enq_rs1_rdy,
    output logic                    enq_rs2_rdy
);

    logic [PREG_NUM-1:0] rdy_tbl;  // one bit per physical register

    assign enq_valid   = disp_valid && accept;
    assign enq_prs1    = disp_prs1;
    assign enq_prs2    = disp_prs2;
    assign enq_prd     = disp_prd;
    // same-cycle wakes are caught by the queue entry itself
    assign enq_rs1_rdy = rdy_tbl[disp_prs1];
    assign enq_rs2_rdy = rdy_tbl[disp_prs2];

    always_comb begin
        case (disp_funct3)
            F3_DIV:  enq_op = OP_DIV;
            F3_DIVU: enq_op = OP_DIVU;
            F3_REM:  enq_op = OP_REM;
            F3_REMU: enq_op = OP_REMU;
            default: enq_op = OP_MUL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdy_tbl <= '1;
        end else begin
            for (int p = 0; p < WAKE_PORTS; p++) begin
                if (wake_valid[p]) begin
                    rdy_tbl[wake_tag[p]] <= 1'b1;
                end
            end
            if (enq_valid) begin
                rdy_tbl[disp_prd] <= 1'b0;  // new producer wins over a stale wake
            end
        end
    end

endmodule

// ==== source/iq_entry_mdu.sv ====
module iq_entry_mdu import mdu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    enq_en,
    input  logic                    shift_en,
    input  mdu_op_t                 new_op,
    input  preg_t                   new_prs1,
    input  preg_t                   new_prs2,
    input  preg_t                   new_prd,
    input  logic                    new_rs1_rdy,
    input  logic                    new_rs2_rdy,
    input  logic                    up_valid,
    input  mdu_op_t                 up_op,
    input  preg_t                   up_prs1,
    input  preg_t                   up_prs2,
    input  preg_t                   up_prd,
    input  logic                    up_rs1_rdy,
    input  logic                    up_rs2_rdy,
    input  logic [WAKE_PORTS-1:0]   wake_valid,
    input  preg_t [WAKE_PORTS-1:0]  wake_tag,
    output mdu_op_t                 cur_op,
    output preg_t                   cur_prs1,
    output preg_t                   cur_prs2,
    output preg_t                   cur_prd,
    output logic                    cur_rs1_rdy,
    output logic                    cur_rs2_rdy,
    output logic                    valid,
    output logic                    rdy
);

    logic    nxt_valid;
    mdu_op_t nxt_op;
    preg_t   nxt_prs1;
    preg_t   nxt_prs2;
    preg_t   nxt_prd;
    logic    nxt_rs1_rdy;
    logic    nxt_rs2_rdy;
    logic    hit1;
    logic    hit2;

    // enqueue beats shift, so a slot refilled in a dequeue cycle takes the new op
    always_comb begin
        if (enq_en) begin
            {nxt_valid, nxt_op, nxt_prs1, nxt_prs2, nxt_prd} =
                {1'b1, new_op, new_prs1, new_prs2, new_prd};
            {nxt_rs1_rdy, nxt_rs2_rdy} = {new_rs1_rdy, new_rs2_rdy};
        end else if (shift_en) begin
            {nxt_valid, nxt_op, nxt_prs1, nxt_prs2, nxt_prd} =
                {up_valid, up_op, up_prs1, up_prs2, up_prd};
            {nxt_rs1_rdy, nxt_rs2_rdy} = {up_rs1_rdy, up_rs2_rdy};
        end else begin
            {nxt_valid, nxt_op, nxt_prs1, nxt_prs2, nxt_prd} =
                {valid, cur_op, cur_prs1, cur_prs2, cur_prd};
            {nxt_rs1_rdy, nxt_rs2_rdy} = {cur_rs1_rdy, cur_rs2_rdy};
        end
    end

    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        for (int p = 0; p < WAKE_PORTS; p++) begin
            hit1 = hit1 | (wake_valid[p] && wake_tag[p] == nxt_prs1);
            hit2 = hit2 | (wake_valid[p] && wake_tag[p] == nxt_prs2);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid       <= 1'b0;
            cur_rs1_rdy <= 1'b0;
            cur_rs2_rdy <= 1'b0;
        end else begin
            valid       <= nxt_valid;
            cur_rs1_rdy <= nxt_rs1_rdy | hit1;
            cur_rs2_rdy <= nxt_rs2_rdy | hit2;
        end
    end

    always_ff @(posedge clk) begin
        cur_op   <= nxt_op;
        cur_prs1 <= nxt_prs1;
        cur_prs2 <= nxt_prs2;
        cur_prd  <= nxt_prd;
    end

    assign rdy = valid && cur_rs1_rdy && cur_rs2_rdy;

endmodule

// ==== source/iq_mdu.sv ====
module iq_mdu import mdu_pkg::*; #(
    parameter int QUEUE_LEN = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          enq_valid,
    input  mdu_op_t                       enq_op,
    input  preg_t                         enq_prs1,
    input  preg_t                         enq_prs2,
    input  preg_t                         enq_prd,
    input  logic                          enq_rs1_rdy,
    input  logic                          enq_rs2_rdy,
    input  logic [WAKE_PORTS-1:0]         wake_valid,
    input  preg_t [WAKE_PORTS-1:0]        wake_tag,
    input  logic                          deq_en,
    input  logic [$clog2(QUEUE_LEN)-1:0]  deq_idx,
    output logic [QUEUE_LEN-1:0]          req_vec,
    output logic [QUEUE_LEN-1:0]          div_vec,
    output logic                          full,
    output mdu_op_t                       iss_op,
    output preg_t                         iss_prs1,
    output preg_t                         iss_prs2,
    output preg_t                         iss_prd
);

    localparam int IDX_W = $clog2(QUEUE_LEN);

    logic [IDX_W:0] tail;      // number of occupied slots
    logic [IDX_W:0] new_tail;

    // one extra slot past the end, always empty, feeds the last shift
    mdu_op_t        op_q   [QUEUE_LEN+1];
    preg_t          prs1_q [QUEUE_LEN+1];
    preg_t          prs2_q [QUEUE_LEN+1];
    preg_t          prd_q  [QUEUE_LEN+1];
    logic [QUEUE_LEN:0] vld_q;
    logic [QUEUE_LEN:0] r1_q;
    logic [QUEUE_LEN:0] r2_q;

    assign op_q[QUEUE_LEN]   = OP_MUL;
    assign prs1_q[QUEUE_LEN] = '0;
    assign prs2_q[QUEUE_LEN] = '0;
    assign prd_q[QUEUE_LEN]  = '0;
    assign vld_q[QUEUE_LEN]  = 1'b0;
    assign r1_q[QUEUE_LEN]   = 1'b0;
    assign r2_q[QUEUE_LEN]   = 1'b0;

    assign new_tail = tail - {{IDX_W{1'b0}}, deq_en};
    assign full     = tail == (IDX_W+1)'(QUEUE_LEN);

    for (genvar i = 0; i < QUEUE_LEN; i++) begin : g_slot
        iq_entry_mdu u_entry (
            .clk         (clk),
            .rst         (rst),
            .flush       (flush),
            .enq_en      (enq_valid && new_tail == (IDX_W+1)'(i)),
            .shift_en    (deq_en && deq_idx <= IDX_W'(i)),
            .new_op      (enq_op),
            .new_prs1    (enq_prs1),
            .new_prs2    (enq_prs2),
            .new_prd     (enq_prd),
            .new_rs1_rdy (enq_rs1_rdy),
            .new_rs2_rdy (enq_rs2_rdy),
            .up_valid    (vld_q[i+1]),
            .up_op       (op_q[i+1]),
            .up_prs1     (prs1_q[i+1]),
            .up_prs2     (prs2_q[i+1]),
            .up_prd      (prd_q[i+1]),
            .up_rs1_rdy  (r1_q[i+1]),
            .up_rs2_rdy  (r2_q[i+1]),
            .wake_valid  (wake_valid),
            .wake_tag    (wake_tag),
            .cur_op      (op_q[i]),
            .cur_prs1    (prs1_q[i]),
            .cur_prs2    (prs2_q[i]),
            .cur_prd     (prd_q[i]),
            .cur_rs1_rdy (r1_q[i]),
            .cur_rs2_rdy (r2_q[i]),
            .valid       (vld_q[i]),
            .rdy         (req_vec[i])
        );
        assign div_vec[i] = vld_q[i] && op_q[i] != OP_MUL;
    end

    assign iss_op   = op_q[deq_idx];
    assign iss_prs1 = prs1_q[deq_idx];
    assign iss_prs2 = prs2_q[deq_idx];
    assign iss_prd  = prd_q[deq_idx];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else begin
            tail <= new_tail + {{IDX_W{1'b0}}, enq_valid};
        end
    end

endmodule

// ==== source/issue_arbiter.sv ====
module issue_arbiter #(
    parameter int QUEUE_LEN = 8
) (
    input  logic [QUEUE_LEN-1:0]          req_vec,
    input  logic [QUEUE_LEN-1:0]          div_vec,
    input  logic                          div_busy,
    output logic                          sel_valid,
    output logic [$clog2(QUEUE_LEN)-1:0]  sel_idx
);

    localparam int IDX_W = $clog2(QUEUE_LEN);

    logic [QUEUE_LEN-1:0] cand;

    assign cand      = req_vec & ~(div_vec & {QUEUE_LEN{div_busy}});
    assign sel_valid = |cand;

    // slot 0 is the oldest, so the lowest index wins
    always_comb begin
        sel_idx = '0;
        for (int i = QUEUE_LEN - 1; i >= 0; i--) begin
            if (cand[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

endmodule

// ==== source/mdu_execute.sv ====
module mdu_execute import mdu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     iss_valid,
    input  mdu_op_t  iss_op,
    input  preg_t    iss_prd,
    input  xlen_t    rd_data1,
    input  xlen_t    rd_data2,
    output logic     div_busy,
    output logic     mul_done,
    output preg_t    mul_tag,
    output xlen_t    mul_data,
    output logic     div_done,
    output preg_t    div_tag,
    output xlen_t    div_data
);

    logic        mul_s1_valid;
    preg_t       mul_s1_tag;
    xlen_t       mul_s1_lo;
    logic [15:0] mul_s1_hi;

    div_state_t  div_state;
    logic [4:0]  div_cnt;
    xlen_t       div_quo;   // dividend shifts out, quotient shifts in
    xlen_t       div_rem;
    xlen_t       div_dsr;
    xlen_t       div_dvd;
    logic        div_neg_q;
    logic        div_neg_r;
    logic        div_is_rem;
    logic        div_zero;
    logic        div_ovf;
    logic        div_start;
    logic        div_signed;
    logic [32:0] div_trial;
    xlen_t       quo_fix;
    xlen_t       rem_fix;

    assign div_start  = iss_valid && iss_op != OP_MUL && div_state == DIV_IDLE;
    assign div_signed = iss_op == OP_DIV || iss_op == OP_REM;
    assign div_busy   = div_state != DIV_IDLE;
    assign div_done   = div_state == DIV_DONE;
    assign div_trial  = {div_rem, div_quo[31]} - {1'b0, div_dsr};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_s1_valid <= 1'b0;
            mul_done     <= 1'b0;
            div_state    <= DIV_IDLE;
        end else begin
            mul_s1_valid <= iss_valid && iss_op == OP_MUL;
            mul_done     <= mul_s1_valid;
            case (div_state)
                DIV_IDLE: div_state <= div_start ? DIV_RUN : DIV_IDLE;
                DIV_RUN:  div_state <= (div_cnt == 5'd31) ? DIV_DONE : DIV_RUN;
                default:  div_state <= DIV_IDLE;
            endcase
        end
    end

    // low 32 bits only: a*b_lo plus the low half of a_lo*b_hi shifted up
    always_ff @(posedge clk) begin
        mul_s1_tag <= iss_prd;
        mul_s1_lo  <= rd_data1 * {16'b0, rd_data2[15:0]};
        mul_s1_hi  <= rd_data1[15:0] * rd_data2[31:16];
        mul_tag    <= mul_s1_tag;
        mul_data   <= mul_s1_lo + {mul_s1_hi, 16'b0};
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            div_tag    <= iss_prd;
            div_cnt    <= '0;
            div_rem    <= '0;
            div_quo    <= (div_signed && rd_data1[31]) ? -rd_data1 : rd_data1;
            div_dsr    <= (div_signed && rd_data2[31]) ? -rd_data2 : rd_data2;
            div_dvd    <= rd_data1;
            div_neg_q  <= div_signed && (rd_data1[31] ^ rd_data2[31]);
            div_neg_r  <= div_signed && rd_data1[31];  // remainder follows dividend
            div_is_rem <= iss_op == OP_REM || iss_op == OP_REMU;
            div_zero   <= rd_data2 == '0;
            div_ovf    <= div_signed && rd_data1 == 32'h8000_0000 && rd_data2 == '1;
        end else if (div_state == DIV_RUN) begin
            div_cnt <= div_cnt + 5'd1;
            div_quo <= {div_quo[30:0], ~div_trial[32]};
            div_rem <= div_trial[32] ? {div_rem[30:0], div_quo[31]} : div_trial[31:0];
        end
    end

    always_comb begin
        quo_fix = div_neg_q ? -div_quo : div_quo;
        rem_fix = div_neg_r ? -div_rem : div_rem;
        if (div_zero) begin
            quo_fix = '1;
            rem_fix = div_dvd;
        end else if (div_ovf) begin
            quo_fix = div_dvd;
            rem_fix = '0;
        end
        div_data = div_is_rem ? rem_fix : quo_fix;
    end

endmodule

// ==== source/mdu_result.sv ====
module mdu_result import mdu_pkg::*; #(
    parameter int PREG_NUM = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ext_wen,
    input  preg_t                   ext_tag,
    input  xlen_t                   ext_data,
    input  logic                    mul_done,
    input  preg_t                   mul_tag,
    input  xlen_t                   mul_data,
    input  logic                    div_done,
    input  preg_t                   div_tag,
    input  xlen_t                   div_data,
    input  preg_t                   rd_addr1,
    input  preg_t                   rd_addr2,
    output xlen_t                   rd_data1,
    output xlen_t                   rd_data2,
    output logic [WAKE_PORTS-1:0]   wake_valid,
    output preg_t [WAKE_PORTS-1:0]  wake_tag,
    output logic                    wb_mul_valid,
    output preg_t                   wb_mul_tag,
    output xlen_t                   wb_mul_data,
    output logic                    wb_div_valid,
    output preg_t                   wb_div_tag,
    output xlen_t                   wb_div_data
);

    xlen_t rf [PREG_NUM];

    // wake goes out in the write cycle, reader issues the cycle after
    assign wake_valid = {div_done, mul_done, ext_wen};
    assign wake_tag   = {div_tag, mul_tag, ext_tag};

    assign rd_data1 = rf[rd_addr1];
    assign rd_data2 = rf[rd_addr2];

    always_ff @(posedge clk) begin
        if (ext_wen) begin
            rf[ext_tag] <= ext_data;
        end
        if (mul_done) begin
            rf[mul_tag] <= mul_data;
        end
        if (div_done) begin
            rf[div_tag] <= div_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_mul_valid <= 1'b0;
            wb_div_valid <= 1'b0;
        end else begin
            wb_mul_valid <= mul_done;
            wb_div_valid <= div_done;
        end
    end

    always_ff @(posedge clk) begin
        wb_mul_tag  <= mul_tag;
        wb_mul_data <= mul_data;
        wb_div_tag  <= div_tag;
        wb_div_data <= div_data;
    end

endmodule

// ==== source/mdu_issue_top.sv ====
module mdu_issue_top import mdu_pkg::*; #(
    parameter int QUEUE_LEN = 8,
    parameter int PREG_NUM  = 64
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     disp_valid,
    input  funct3_t  disp_funct3,
    input  preg_t    disp_prs1,
    input  preg_t    disp_prs2,
    input  preg_t    disp_prd,
    input  logic     ext_wen,
    input  preg_t    ext_tag,
    input  xlen_t    ext_data,
    output logic     ready,
    output logic     wb_mul_valid,
    output preg_t    wb_mul_tag,
    output xlen_t    wb_mul_data,
    output logic     wb_div_valid,
    output preg_t    wb_div_tag,
    output xlen_t    wb_div_data
);

    logic                          enq_valid;
    mdu_op_t                       enq_op;
    preg_t                         enq_prs1;
    preg_t                         enq_prs2;
    preg_t                         enq_prd;
    logic                          enq_rs1_rdy;
    logic                          enq_rs2_rdy;
    logic [WAKE_PORTS-1:0]         wake_valid;
    preg_t [WAKE_PORTS-1:0]        wake_tag;
    logic [QUEUE_LEN-1:0]          req_vec;
    logic [QUEUE_LEN-1:0]          div_vec;
    logic                          full;
    logic                          sel_valid;
    logic [$clog2(QUEUE_LEN)-1:0]  sel_idx;
    mdu_op_t                       iss_op;
    preg_t                         iss_prs1;
    preg_t                         iss_prs2;
    preg_t                         iss_prd;
    xlen_t                         rd_data1;
    xlen_t                         rd_data2;
    logic                          div_busy;
    logic                          mul_done;
    preg_t                         mul_tag;
    xlen_t                         mul_data;
    logic                          div_done;
    preg_t                         div_tag;
    xlen_t                         div_data;

    assign ready = ~full;

    mdu_decode #(.PREG_NUM(PREG_NUM)) u_decode (
        .clk(clk), .rst(rst), .flush(flush),
        .disp_valid(disp_valid), .disp_funct3(disp_funct3),
        .disp_prs1(disp_prs1), .disp_prs2(disp_prs2), .disp_prd(disp_prd),
        .accept(ready), .wake_valid(wake_valid), .wake_tag(wake_tag),
        .enq_valid(enq_valid), .enq_op(enq_op), .enq_prs1(enq_prs1),
        .enq_prs2(enq_prs2), .enq_prd(enq_prd),
        .enq_rs1_rdy(enq_rs1_rdy), .enq_rs2_rdy(enq_rs2_rdy)
    );

    iq_mdu #(.QUEUE_LEN(QUEUE_LEN)) u_iq (
        .clk(clk), .rst(rst), .flush(flush),
        .enq_valid(enq_valid), .enq_op(enq_op), .enq_prs1(enq_prs1),
        .enq_prs2(enq_prs2), .enq_prd(enq_prd),
        .enq_rs1_rdy(enq_rs1_rdy), .enq_rs2_rdy(enq_rs2_rdy),
        .wake_valid(wake_valid), .wake_tag(wake_tag),
        .deq_en(sel_valid), .deq_idx(sel_idx),
        .req_vec(req_vec), .div_vec(div_vec), .full(full),
        .iss_op(iss_op), .iss_prs1(iss_prs1), .iss_prs2(iss_prs2), .iss_prd(iss_prd)
    );

    issue_arbiter #(.QUEUE_LEN(QUEUE_LEN)) u_arb (
        .req_vec(req_vec), .div_vec(div_vec), .div_busy(div_busy),
        .sel_valid(sel_valid), .sel_idx(sel_idx)
    );

    mdu_execute u_exec (
        .clk(clk), .rst(rst), .flush(flush),
        .iss_valid(sel_valid), .iss_op(iss_op), .iss_prd(iss_prd),
        .rd_data1(rd_data1), .rd_data2(rd_data2), .div_busy(div_busy),
        .mul_done(mul_done), .mul_tag(mul_tag), .mul_data(mul_data),
        .div_done(div_done), .div_tag(div_tag), .div_data(div_data)
    );

    mdu_result #(.PREG_NUM(PREG_NUM)) u_result (
        .clk(clk), .rst(rst),
        .ext_wen(ext_wen), .ext_tag(ext_tag), .ext_data(ext_data),
        .mul_done(mul_done), .mul_tag(mul_tag), .mul_data(mul_data),
        .div_done(div_done), .div_tag(div_tag), .div_data(div_data),
        .rd_addr1(iss_prs1), .rd_addr2(iss_prs2),  // operands read in the issue cycle
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .wake_valid(wake_valid), .wake_tag(wake_tag),
        .wb_mul_valid(wb_mul_valid), .wb_mul_tag(wb_mul_tag), .wb_mul_data(wb_mul_data),
        .wb_div_valid(wb_div_valid), .wb_div_tag(wb_div_tag), .wb_div_data(wb_div_data)
    );

endmodule

// ==== testbench/tb_mdu_issue.sv ====
module tb_mdu_issue import mdu_pkg::*; ();

    localparam int NROWS = 24;

    logic    clk;
    logic    rst;
    logic    flush;
    logic    disp_valid;
    funct3_t disp_funct3;
    preg_t   disp_prs1;
    preg_t   disp_prs2;
    preg_t   disp_prd;
    logic    ext_wen;
    preg_t   ext_tag;
    xlen_t   ext_data;
    logic    ready;
    logic    wb_mul_valid;
    preg_t   wb_mul_tag;
    xlen_t   wb_mul_data;
    logic    wb_div_valid;
    preg_t   wb_div_tag;
    xlen_t   wb_div_data;

    // stimulus table with expected results
    funct3_t tbl_f3  [NROWS];
    xlen_t   tbl_a   [NROWS];
    xlen_t   tbl_b   [NROWS];
    xlen_t   tbl_exp [NROWS];

    // scoreboard indexed by destination tag
    xlen_t   exp_val    [64];
    logic    pend       [64];
    logic    exp_is_div [64];
    int      n_pend;
    int      wb_seen;
    preg_t   chain_q [$];
    preg_t   next_tag;
    logic [31:0] lfsr_state;

    mdu_issue_top #(.QUEUE_LEN(8), .PREG_NUM(64)) dut_i (
        .clk(clk), .rst(rst), .flush(flush),
        .disp_valid(disp_valid), .disp_funct3(disp_funct3),
        .disp_prs1(disp_prs1), .disp_prs2(disp_prs2), .disp_prd(disp_prd),
        .ext_wen(ext_wen), .ext_tag(ext_tag), .ext_data(ext_data),
        .ready(ready),
        .wb_mul_valid(wb_mul_valid), .wb_mul_tag(wb_mul_tag), .wb_mul_data(wb_mul_data),
        .wb_div_valid(wb_div_valid), .wb_div_tag(wb_div_tag), .wb_div_data(wb_div_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output xlen_t w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic preg_t alloc_tag();
        preg_t t;
        t = next_tag;
        next_tag = (next_tag == 6'd63) ? 6'd1 : next_tag + 6'd1;
        return t;
    endfunction

    // RV32M rules including divide by zero and signed overflow
    function automatic xlen_t ref_result(input funct3_t f3, input xlen_t a, input xlen_t b);
        logic               ovf;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sres;
        xlen_t              res;
        ovf = a == 32'h8000_0000 && b == 32'hffff_ffff;
        sa  = a;
        sb  = b;
        case (f3)
            F3_DIV: begin
                if (b == 0) begin
                    res = 32'hffff_ffff;
                end else if (ovf) begin
                    res = a;
                end else begin
                    sres = sa / sb;
                    res  = sres;
                end
            end
            F3_REM: begin
                if (b == 0) begin
                    res = a;
                end else if (ovf) begin
                    res = 32'h0;
                end else begin
                    sres = sa % sb;  // sign follows the dividend
                    res  = sres;
                end
            end
            F3_DIVU: res = (b == 0) ? 32'hffff_ffff : a / b;
            F3_REMU: res = (b == 0) ? a : a % b;
            default: res = a * b;
        endcase
        return res;
    endfunction

    task automatic ext_write(input preg_t tag, input xlen_t data);
        @(posedge clk);
        disp_valid <= 1'b0;
        ext_wen    <= 1'b1;
        ext_tag    <= tag;
        ext_data   <= data;
    endtask

    task automatic dispatch(input funct3_t f3, input preg_t s1, input preg_t s2,
                            input preg_t d, input xlen_t exp);
        @(posedge clk);
        ext_wen     <= 1'b0;
        disp_valid  <= 1'b1;
        disp_funct3 <= f3;
        disp_prs1   <= s1;
        disp_prs2   <= s2;
        disp_prd    <= d;
        if (pend[d]) begin
            fail_now("destination tag reused while its result is still pending");
        end
        exp_val[d]    = exp;
        exp_is_div[d] = f3 != F3_MUL;
        pend[d]       = 1'b1;
        n_pend++;
    endtask

    task automatic quiet();
        @(posedge clk);
        disp_valid <= 1'b0;
        ext_wen    <= 1'b0;
        flush      <= 1'b0;
    endtask

    task automatic wait_drain();
        int idle;
        int last;
        idle = 0;
        last = wb_seen;
        while (n_pend != 0) begin
            @(posedge clk);
            if (wb_seen != last) begin
                last = wb_seen;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle >= 100) begin
                fail_now("timeout: a write-back did not arrive within 100 cycles");
            end
        end
    endtask

    task automatic take_result(input preg_t tag, input xlen_t data, input logic is_div,
                               input string name);
        if (!pend[tag] || exp_is_div[tag] != is_div) begin
            fail_now($sformatf("unexpected write-back for tag %0d", tag));
        end
        if (!is_div && chain_q.size() > 0) begin
            check_tag("wb_mul_tag", tag, chain_q.pop_front());
        end
        check_data(name, data, exp_val[tag]);
        pend[tag] = 1'b0;
        n_pend--;
        wb_seen++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (wb_mul_valid) take_result(wb_mul_tag, wb_mul_data, 1'b0, "wb_mul_data");
            if (wb_div_valid) take_result(wb_div_tag, wb_div_data, 1'b1, "wb_div_data");
        end
    end

    task automatic build_table();
        funct3_t f3_list [5];
        funct3_t fix_f3  [9];
        xlen_t   fix_a   [9];
        xlen_t   fix_b   [9];
        xlen_t   w;
        f3_list = '{F3_MUL, F3_DIV, F3_DIVU, F3_REM, F3_REMU};
        // divide by zero, min over minus one, negative operands
        fix_f3 = '{F3_DIV, F3_DIVU, F3_REM, F3_REMU, F3_DIV, F3_REM, F3_DIV, F3_REM, F3_MUL};
        fix_a  = '{32'h1234_5678, 32'hdead_beef, 32'h8765_4321, 32'h0000_0042,
                   32'h8000_0000, 32'h8000_0000, 32'hffff_fff9, 32'hffff_fff9,
                   32'hffff_fffd};
        fix_b  = '{32'h0, 32'h0, 32'h0, 32'h0, 32'hffff_ffff, 32'hffff_ffff,
                   32'h2, 32'h2, 32'h5};
        for (int r = 0; r < NROWS; r++) begin
            if (r < 9) begin
                tbl_f3[r] = fix_f3[r];
                tbl_a[r]  = fix_a[r];
                tbl_b[r]  = fix_b[r];
            end else begin
                rand_bits(3, w);
                tbl_f3[r] = f3_list[w % 5];
                rand_bits(32, tbl_a[r]);
                rand_bits(32, tbl_b[r]);
            end
        end
        for (int r = 0; r < NROWS; r++) begin
            tbl_exp[r] = ref_result(tbl_f3[r], tbl_a[r], tbl_b[r]);
        end
    endtask

    task automatic apply_table();
        preg_t ta;
        preg_t tb;
        preg_t td;
        int    lat;
        logic  is_mul;
        for (int r = 0; r < NROWS; r++) begin
            ta = alloc_tag();
            tb = alloc_tag();
            td = alloc_tag();
            ext_write(ta, tbl_a[r]);
            ext_write(tb, tbl_b[r]);
            dispatch(tbl_f3[r], ta, tb, td, tbl_exp[r]);
            quiet();
            is_mul = tbl_f3[r] == F3_MUL;
            lat = 1;  // dispatch cycle counts as 1
            while (!(is_mul ? wb_mul_valid : wb_div_valid)) begin
                if (lat >= 100) fail_now("timeout: write-back of a table row never came");
                @(posedge clk);
                lat++;
            end
            if (is_mul) begin
                // issue one cycle after dispatch, then 3 to write-back
                check_data("mul_latency", xlen_t'(lat), 32'd5);
                check_tag("wb_mul_tag", wb_mul_tag, td);
            end else begin
                check_tag("wb_div_tag", wb_div_tag, td);
            end
            wait_drain();
        end
    endtask

    task automatic mul_chain();
        preg_t t1;
        preg_t t2;
        preg_t d [3];
        xlen_t va;
        xlen_t vb;
        xlen_t p;
        t1 = alloc_tag();
        t2 = alloc_tag();
        rand_bits(32, va);
        rand_bits(32, vb);
        ext_write(t1, va);
        ext_write(t2, vb);
        p = va;
        for (int i = 0; i < 3; i++) begin
            d[i] = alloc_tag();
            chain_q.push_back(d[i]);
            p = p * vb;
            dispatch(F3_MUL, (i == 0) ? t1 : d[i-1], t2, d[i], p);
        end
        quiet();
        wait_drain();
    endtask

    // the first divide holds the divider, so the second stays queued and its tag busy
    task automatic fill_queue();
        preg_t s1;
        preg_t s2;
        preg_t d0;
        preg_t tbusy;
        preg_t m;
        xlen_t v1;
        xlen_t v2;
        xlen_t vbusy;
        int    cnt;
        s1 = alloc_tag();
        s2 = alloc_tag();
        d0 = alloc_tag();
        tbusy = alloc_tag();
        rand_bits(32, v1);
        rand_bits(16, v2);
        rand_bits(32, vbusy);
        ext_write(s1, v1);
        ext_write(s2, v2);
        dispatch(F3_DIV, s1, s2, d0, ref_result(F3_DIV, v1, v2));
        dispatch(F3_REMU, s1, s2, tbusy, ref_result(F3_REMU, v1, v2));
        for (int i = 0; i < 7; i++) begin
            m = alloc_tag();
            dispatch(F3_MUL, tbusy, s2, m, vbusy * v2);
        end
        quiet();
        cnt = 0;
        while (ready) begin
            if (cnt >= 10) fail_now("ready stayed high with a full queue");
            @(posedge clk);
            cnt++;
        end
        repeat (10) @(posedge clk);
        if (n_pend != 9) fail_now("an op completed before its sources were written");
        ext_write(tbusy, vbusy);
        quiet();
        wait_drain();
    endtask

    task automatic flush_pending();
        preg_t s1;
        preg_t s2;
        preg_t d0;
        preg_t tbusy;
        preg_t m;
        xlen_t v;
        s1 = alloc_tag();
        s2 = alloc_tag();
        d0 = alloc_tag();
        tbusy = alloc_tag();
        m = alloc_tag();
        ext_write(s1, 32'h0000_1000);
        ext_write(s2, 32'h0000_0003);
        dispatch(F3_DIV, s1, s2, d0, 32'h0000_0555);
        dispatch(F3_DIVU, s1, s2, tbusy, 32'h0000_0555);
        dispatch(F3_MUL, tbusy, s2, m, 32'h0000_0fff);
        quiet();
        repeat (5) @(posedge clk);
        @(posedge clk);
        flush <= 1'b1;
        pend[d0]    = 1'b0;
        pend[tbusy] = 1'b0;
        pend[m]     = 1'b0;
        n_pend      = 0;
        quiet();
        repeat (50) @(posedge clk);  // killed work must stay silent
        if (!ready) fail_now("ready is low after flush");
        s1 = alloc_tag();
        m = alloc_tag();
        rand_bits(32, v);
        ext_write(s1, v);
        dispatch(F3_MUL, s1, s2, m, v * 32'd3);
        quiet();
        wait_drain();
    endtask

    initial begin
        rst         = 1'b1;
        flush       = 1'b0;
        disp_valid  = 1'b0;
        disp_funct3 = F3_MUL;
        disp_prs1   = '0;
        disp_prs2   = '0;
        disp_prd    = '0;
        ext_wen     = 1'b0;
        ext_tag     = '0;
        ext_data    = '0;
        lfsr_state  = 32'h28c7_13fe;
        next_tag    = 6'd1;
        n_pend      = 0;
        wb_seen     = 0;
        for (int i = 0; i < 64; i++) begin
            pend[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        build_table();
        apply_table();
        mul_chain();
        fill_queue();
        flush_pending();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== flist.f ====
source/mdu_pkg.sv
source/mdu_decode.sv
source/iq_entry_mdu.sv
source/iq_mdu.sv
source/issue_arbiter.sv
source/mdu_execute.sv
source/mdu_result.sv
source/mdu_issue_top.sv
testbench/tb_mdu_issue.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module tb_mdu_issue -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1
